// File: common/tensor_pkg.sv
`default_nettype none

package tensor_pkg;

    // sizes
    localparam int word_width  = 32;
    localparam int num_lanes   = 16;
    localparam int num_octets  = num_lanes / 8;
    // distance between the two thread groups that share one octet
    localparam int lane_offset = 4 * num_octets;
    localparam int num_warps   = 4;
    localparam int wid_width   = 2;
    localparam int reg_width   = 5;

    // latencies and queue depths
    localparam int dpu_latency  = 4;
    localparam int meta_depth   = 2 * dpu_latency;
    localparam int result_depth = 2;

    typedef logic [word_width-1:0] word_t;

    typedef word_t [num_lanes-1:0] lane_data_t;

    // words 0-3 from the low thread group, 4-7 from the offset group
    typedef word_t [7:0] octet_data_t;

    // indexed [row][col]
    typedef word_t [3:0][3:0] tile_t;
    typedef word_t [3:0][1:0] a_tile_t;
    typedef word_t [1:0][3:0] b_tile_t;

    typedef struct packed {
        logic [wid_width-1:0] wid;
        logic [num_lanes-1:0] tmask;
        logic [31:0]          pc;
        logic                 wb;
        logic [reg_width-1:0] rd;
    } meta_t;

    typedef struct packed {
        meta_t      meta;
        logic [1:0] step;
        logic       last;
        lane_data_t rs1;
        lane_data_t rs2;
        lane_data_t rs3;
    } exec_req_t;

    typedef struct packed {
        octet_data_t          a;
        octet_data_t          b;
        octet_data_t          c;
        logic [wid_width-1:0] wid;
        logic [1:0]           step;
        logic                 last;
    } octet_op_t;

    typedef struct packed {
        tile_t                d;
        logic [wid_width-1:0] wid;
    } octet_result_t;

    typedef struct packed {
        meta_t      meta;
        lane_data_t data;
    } commit_t;

endpackage

`default_nettype wire

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int  depth  = 2,
    parameter type data_t = logic [31:0]
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  logic  pop,
    input  data_t data_in,
    output data_t data_out,
    output logic  full,
    output logic  empty
);

    data_t mem [depth];

    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] count;

    assign full     = (count == depth);
    assign empty    = (count == 0);
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: octet/tensor_dpu.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_dpu import tensor_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid_in,
    output logic                 ready_in,
    input  a_tile_t              a_tile,
    input  b_tile_t              b_tile,
    input  tile_t                c_tile,
    input  logic [wid_width-1:0] wid,
    output logic                 valid_out,
    input  logic                 ready_out,
    output octet_result_t        d
);

    logic [dpu_latency-1:0] valid_q;

    // stage 0 holds the two partial products per element and c
    tile_t                prod0_q;
    tile_t                prod1_q;
    tile_t                c_q;
    logic [wid_width-1:0] wid_q;

    // stage 1 holds the sum, later stages only carry it
    octet_result_t res_q [1:dpu_latency-1];
    tile_t         sum;

    // the whole pipeline stalls together
    assign ready_in  = ready_out;
    assign valid_out = valid_q[dpu_latency-1];
    assign d         = res_q[dpu_latency-1];

    always_comb begin
        for (int m = 0; m < 4; m++) begin
            for (int n = 0; n < 4; n++) begin
                sum[m][n] = c_q[m][n] + prod0_q[m][n] + prod1_q[m][n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (ready_out) begin
            valid_q <= {valid_q[dpu_latency-2:0], valid_in};
        end
    end

    always_ff @(posedge clk) begin
        if (ready_out) begin
            for (int m = 0; m < 4; m++) begin
                for (int n = 0; n < 4; n++) begin
                    // only the low 32 bits of each product are kept
                    prod0_q[m][n] <= a_tile[m][0] * b_tile[0][n];
                    prod1_q[m][n] <= a_tile[m][1] * b_tile[1][n];
                end
            end
            c_q          <= c_tile;
            wid_q        <= wid;
            res_q[1].d   <= sum;
            res_q[1].wid <= wid_q;
            for (int s = 2; s < dpu_latency; s++) begin
                res_q[s] <= res_q[s-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: octet/tensor_octet.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_octet import tensor_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  octet_op_t     op,
    input  logic          op_valid,
    output logic          op_ready,
    output octet_result_t result,
    output logic          result_valid,
    input  logic          result_pop
);

    // first half of each pair, kept per warp until the last beat arrives
    word_t [3:0] a_stage [num_warps];
    word_t [3:0] b_stage [num_warps];
    octet_data_t c_stage [num_warps];

    // half of the incoming beat picked by the step
    word_t [3:0] a_half;
    word_t [3:0] b_half;

    a_tile_t a_tile;
    b_tile_t b_tile;
    tile_t   c_tile;

    logic          first_fire;
    logic          dpu_valid_in;
    logic          dpu_ready_in;
    logic          dpu_valid_out;
    octet_result_t dpu_d;
    logic          buf_full;
    logic          buf_empty;

    assign op_ready     = dpu_ready_in;
    assign first_fire   = op_valid && op_ready && !op.last;
    assign dpu_valid_in = op_valid && op.last;

    // step bit 0 picks the A column pair, step bit 1 the B row half
    always_comb begin
        if (op.step[0]) begin
            a_half = {op.a[7], op.a[6], op.a[3], op.a[2]};
        end else begin
            a_half = {op.a[5], op.a[4], op.a[1], op.a[0]};
        end
        if (op.step[1]) begin
            b_half = op.b[7:4];
        end else begin
            b_half = op.b[3:0];
        end
    end

    always_ff @(posedge clk) begin
        if (first_fire) begin
            a_stage[op.wid] <= a_half;
            b_stage[op.wid] <= b_half;
            c_stage[op.wid] <= op.c;
        end
    end

    // tile assembly from the stored half and the incoming half
    always_comb begin
        int lo;
        for (int r = 0; r < 4; r++) begin
            a_tile[r][0] = a_stage[op.wid][r];
            a_tile[r][1] = a_half[r];
        end
        b_tile[0] = b_stage[op.wid];
        b_tile[1] = b_half;
        for (int r = 0; r < 4; r++) begin
            // rows use words 0/2, 1/3, 4/6 and 5/7
            lo = (r / 2) * 4 + (r % 2);
            c_tile[r][0] = c_stage[op.wid][lo];
            c_tile[r][1] = op.c[lo];
            c_tile[r][2] = c_stage[op.wid][lo + 2];
            c_tile[r][3] = op.c[lo + 2];
        end
    end

    tensor_dpu i_dpu (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (dpu_valid_in),
        .ready_in  (dpu_ready_in),
        .a_tile    (a_tile),
        .b_tile    (b_tile),
        .c_tile    (c_tile),
        .wid       (op.wid),
        .valid_out (dpu_valid_out),
        .ready_out (!buf_full),
        .d         (dpu_d)
    );

    // absorbs commit back-pressure before the dpu has to stall
    sync_fifo #(
        .depth  (result_depth),
        .data_t (octet_result_t)
    ) i_result_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (dpu_valid_out && !buf_full),
        .pop      (result_pop),
        .data_in  (dpu_d),
        .data_out (result),
        .full     (buf_full),
        .empty    (buf_empty)
    );

    assign result_valid = !buf_empty;

endmodule

`default_nettype wire

// File: hdl/tensor_core.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_core import tensor_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  exec_req_t exec_req,
    input  logic      exec_valid,
    output logic      exec_ready,
    output commit_t   commit,
    output logic      commit_valid,
    input  logic      commit_ready
);

    octet_result_t         oct_result [num_octets];
    logic [num_octets-1:0] oct_op_ready;
    logic [num_octets-1:0] oct_result_valid;

    meta_t                meta_head [num_warps];
    logic [num_warps-1:0] meta_full;
    logic                 meta_any_full;

    logic                 op_valid;
    logic                 exec_fire;
    logic                 commit_fire;
    logic                 results_pop;
    logic                 subcommit;
    logic [wid_width-1:0] res_wid;
    lane_data_t           beat0_data;
    lane_data_t           beat1_data;

    // octets and metadata queues must accept the same beats
    // nothing is taken while the block is in reset
    assign meta_any_full = |meta_full;
    assign op_valid      = exec_valid && !meta_any_full && !reset;
    assign exec_ready    = (&oct_op_ready) && !meta_any_full && !reset;
    assign exec_fire     = exec_valid && exec_ready;

    for (genvar i = 0; i < num_octets; i++) begin : g_octet
        octet_op_t op;

        // lanes 4i..4i+3, then the same four lanes of the offset group
        assign op = '{
            a:    {exec_req.rs1[lane_offset + 4*i +: 4], exec_req.rs1[4*i +: 4]},
            b:    {exec_req.rs2[lane_offset + 4*i +: 4], exec_req.rs2[4*i +: 4]},
            c:    {exec_req.rs3[lane_offset + 4*i +: 4], exec_req.rs3[4*i +: 4]},
            wid:  exec_req.meta.wid,
            step: exec_req.step,
            last: exec_req.last
        };

        tensor_octet i_octet (
            .clk          (clk),
            .reset        (reset),
            .op           (op),
            .op_valid     (op_valid),
            .op_ready     (oct_op_ready[i]),
            .result       (oct_result[i]),
            .result_valid (oct_result_valid[i]),
            .result_pop   (results_pop)
        );
    end

    // octets run in lockstep so octet 0 speaks for all
    assign res_wid      = oct_result[0].wid;
    assign commit_valid = &oct_result_valid;
    assign commit_fire  = commit_valid && commit_ready;
    assign results_pop  = commit_fire && subcommit;

    // one queue per warp so the two beats of a pair find their own metadata
    for (genvar w = 0; w < num_warps; w++) begin : g_meta
        logic meta_push;
        logic meta_pop;

        assign meta_push = exec_fire && !exec_req.last && (exec_req.meta.wid == wid_width'(w));
        assign meta_pop  = results_pop && (res_wid == wid_width'(w));

        sync_fifo #(
            .depth  (meta_depth),
            .data_t (meta_t)
        ) i_meta_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (meta_push),
            .pop      (meta_pop),
            .data_in  (exec_req.meta),
            .data_out (meta_head[w]),
            .full     (meta_full[w]),
            .empty    ()
        );
    end

    // each octet holds 16 results but owns only 8 lanes, so two beats
    always_comb begin
        for (int i = 0; i < num_octets; i++) begin
            beat0_data[4*i + 0] = oct_result[i].d[0][0];
            beat0_data[4*i + 1] = oct_result[i].d[1][0];
            beat0_data[4*i + 2] = oct_result[i].d[0][2];
            beat0_data[4*i + 3] = oct_result[i].d[1][2];
            beat0_data[lane_offset + 4*i + 0] = oct_result[i].d[2][0];
            beat0_data[lane_offset + 4*i + 1] = oct_result[i].d[3][0];
            beat0_data[lane_offset + 4*i + 2] = oct_result[i].d[2][2];
            beat0_data[lane_offset + 4*i + 3] = oct_result[i].d[3][2];

            beat1_data[4*i + 0] = oct_result[i].d[0][1];
            beat1_data[4*i + 1] = oct_result[i].d[1][1];
            beat1_data[4*i + 2] = oct_result[i].d[0][3];
            beat1_data[4*i + 3] = oct_result[i].d[1][3];
            beat1_data[lane_offset + 4*i + 0] = oct_result[i].d[2][1];
            beat1_data[lane_offset + 4*i + 1] = oct_result[i].d[3][1];
            beat1_data[lane_offset + 4*i + 2] = oct_result[i].d[2][3];
            beat1_data[lane_offset + 4*i + 3] = oct_result[i].d[3][3];
        end
    end

    // commits finish one warp at a time, so a single bit tracks the beat
    always_ff @(posedge clk) begin
        if (reset) begin
            subcommit <= 1'b0;
        end else if (commit_fire) begin
            subcommit <= ~subcommit;
        end
    end

    assign commit.meta = meta_head[res_wid];
    assign commit.data = subcommit ? beat1_data : beat0_data;

endmodule

`default_nettype wire

// File: verification/tb_tensor_tasks.svh
`ifndef TB_TENSOR_TASKS_SVH
`define TB_TENSOR_TASKS_SVH

function automatic word_t xorshift32(input word_t x);
    word_t s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic word_t next_op_random();
    op_rng = xorshift32(op_rng);
    return op_rng;
endfunction

function automatic exec_req_t random_req(input int wid, input logic [1:0] step,
                                         input logic last);
    exec_req_t   req;
    logic [63:0] bits;
    bits         = {next_op_random(), next_op_random()};
    req.meta     = bits[$bits(meta_t)-1:0];
    req.meta.wid = wid_width'(wid);
    req.step     = step;
    req.last     = last;
    for (int l = 0; l < num_lanes; l++) begin
        req.rs1[l] = next_op_random();
        req.rs2[l] = next_op_random();
        req.rs3[l] = next_op_random();
    end
    return req;
endfunction

// word j of one octet's operand, low thread group first
function automatic word_t octet_word(input lane_data_t rs, input int i, input int j);
    return (j < 4) ? rs[4*i + j] : rs[lane_offset + 4*i + j - 4];
endfunction

// A half is words 0,1,4,5 or 2,3,6,7 by step bit 0
function automatic int a_index(input logic [1:0] step, input int r);
    return ((r < 2) ? r : r + 2) + (step[0] ? 2 : 0);
endfunction

// expected commit data of a pair from its two beats
function automatic void model_pair(input exec_req_t fst, input exec_req_t lst,
                                   output lane_data_t beat0, output lane_data_t beat1);
    int    c_lo [4] = '{0, 1, 4, 5};
    int    lane;
    int    row;
    word_t a0;
    word_t a1;
    word_t c;
    word_t d [4][4];
    for (int i = 0; i < num_octets; i++) begin
        for (int m = 0; m < 4; m++) begin
            for (int n = 0; n < 4; n++) begin
                a0 = octet_word(fst.rs1, i, a_index(fst.step, m));
                a1 = octet_word(lst.rs1, i, a_index(lst.step, m));
                // even columns from the stored half, odd from the incoming one
                c = (n % 2 == 0) ? octet_word(fst.rs3, i, c_lo[m] + n / 2 * 2)
                                 : octet_word(lst.rs3, i, c_lo[m] + n / 2 * 2);
                d[m][n] = c + a0 * octet_word(fst.rs2, i, n + (fst.step[1] ? 4 : 0))
                            + a1 * octet_word(lst.rs2, i, n + (lst.step[1] ? 4 : 0));
            end
        end
        for (int g = 0; g < 2; g++) begin
            for (int t = 0; t < 4; t++) begin
                lane        = g * lane_offset + 4*i + t;
                row         = 2*g + t % 2;
                beat0[lane] = d[row][2 * (t / 2)];
                beat1[lane] = d[row][1 + 2 * (t / 2)];
            end
        end
    end
endfunction

task automatic compare_meta(input string name, input meta_t want, input meta_t got);
    if (got !== want) begin
        $display("** Error at %0t: %s expected %h, got %h", $time, name, want, got);
        value_errors++;
    end
endtask

task automatic compare_lane_data(input string name, input lane_data_t want,
                                 input lane_data_t got);
    for (int l = 0; l < num_lanes; l++) begin
        if (got[l] !== want[l]) begin
            $display("** Error at %0t: %s[%0d] expected %h, got %h",
                     $time, name, l, want[l], got[l]);
            value_errors++;
        end
    end
endtask

task automatic check_commit();
    commit_t want;
    beats_seen++;
    if (expected_q.size() == 0) begin
        $display("at %0t a commit beat arrived while none was outstanding", $time);
        other_errors++;
    end else begin
        want = expected_q.pop_front();
        compare_meta("commit.meta", want.meta, commit.meta);
        compare_lane_data("commit.data", want.data, commit.data);
    end
endtask

// both handshake outputs stay low while reset is held
task automatic check_reset_outputs();
    if (exec_ready !== 1'b0) begin
        $display("exec_ready is not low during reset");
        other_errors++;
    end
    if (commit_valid !== 1'b0) begin
        $display("commit_valid is not low during reset");
        other_errors++;
    end
endtask

// a last beat closes the pair and queues both expected commit beats
task automatic record_accept(input exec_req_t req);
    commit_t want0;
    commit_t want1;
    if (!req.last) begin
        first_beat[req.meta.wid] = req;
    end else begin
        want0.meta = first_beat[req.meta.wid].meta;
        want1.meta = want0.meta;
        model_pair(first_beat[req.meta.wid], req, want0.data, want1.data);
        expected_q.push_back(want0);
        expected_q.push_back(want1);
    end
endtask

// called on a falling edge, returns on the falling edge after acceptance
task automatic send_beat(input exec_req_t req);
    exec_req   = req;
    exec_valid = 1'b1;
    while (!exec_ready) begin
        @(negedge clk);
    end
    record_accept(req);
    @(negedge clk);
    exec_valid = 1'b0;
endtask

task automatic send_pair(input int wid, input logic [1:0] step);
    send_beat(random_req(wid, step, 1'b0));
    send_beat(random_req(wid, step, 1'b1));
endtask

task automatic set_ready_mode(input ready_mode_t mode);
    @(posedge clk);
    ready_mode = mode;
    @(negedge clk);
endtask

// a few idle cycles after the last beat catch duplicates
task automatic wait_drain();
    while (expected_q.size() != 0) begin
        @(negedge clk);
    end
    repeat (8) @(negedge clk);
endtask

task automatic single_pair();
    int waited;
    waited = 0;
    if (commit_valid !== 1'b0) begin
        $display("commit_valid is not low after reset");
        other_errors++;
    end
    while (exec_ready !== 1'b1 && waited < 10) begin
        @(negedge clk);
        waited++;
    end
    if (exec_ready !== 1'b1) begin
        $display("exec_ready did not rise after reset");
        other_errors++;
    end
    send_pair(0, 2'd0);
    wait_drain();
endtask

task automatic step_selection();
    for (int s = 0; s < 4; s++) begin
        send_pair(s, 2'(s));
    end
    wait_drain();
endtask

// warp 1 completes first, so its beats must come out first
task automatic interleaved_warps();
    exec_req_t f1;
    exec_req_t f2;
    f1 = random_req(1, 2'd1, 1'b0);
    f2 = random_req(2, 2'd2, 1'b0);
    send_beat(f1);
    send_beat(f2);
    send_beat(random_req(1, 2'd1, 1'b1));
    send_beat(random_req(2, 2'd2, 1'b1));
    wait_drain();
endtask

task automatic commit_stall();
    int start;
    int waited;
    bit fell;
    start  = beats_seen;
    waited = 0;
    fell   = 1'b0;
    set_ready_mode(ready_held);
    fork
        begin
            for (int p = 0; p < 8; p++) begin
                send_pair(p % num_warps, 2'(p));
            end
        end
        begin
            while (!fell && waited < 100) begin
                @(negedge clk);
                fell = !exec_ready;
                waited++;
            end
            if (!fell) begin
                $display("exec_ready never fell while commits were held back");
                other_errors++;
            end
            repeat (4) @(negedge clk);
            set_ready_mode(ready_always);
        end
    join
    wait_drain();
    if (beats_seen - start != 16) begin
        $display("%0d commit beats delivered after the stall, 16 expected",
                 beats_seen - start);
        other_errors++;
    end
endtask

task automatic random_commit_ready();
    logic [num_warps-1:0] pending;
    word_t                r;
    int                   w;
    pending = '0;
    set_ready_mode(ready_random);
    for (int k = 0; k < 60; k++) begin
        r = next_op_random();
        w = r % num_warps;
        send_beat(random_req(w, r[5:4], pending[w]));
        pending[w] = ~pending[w];
    end
    // close the pairs still open
    for (int v = 0; v < num_warps; v++) begin
        if (pending[v]) begin
            send_beat(random_req(v, 2'd3, 1'b1));
        end
    end
    wait_drain();
    set_ready_mode(ready_always);
endtask

`endif

// File: verification/tb_tensor_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tensor_core import tensor_pkg::*; ();

    // the tests need roughly 400 cycles
    localparam int timeout_cycles = 4000;

    typedef enum {ready_always, ready_held, ready_random} ready_mode_t;

    logic      clk;
    logic      reset;
    exec_req_t exec_req;
    logic      exec_valid;
    logic      exec_ready;
    commit_t   commit;
    logic      commit_valid;
    logic      commit_ready;

    ready_mode_t ready_mode;
    word_t       op_rng;
    word_t       ready_rng;
    // first beat of the open pair of each warp
    exec_req_t   first_beat [num_warps];
    commit_t     expected_q [$];
    int          beats_seen;
    int          value_errors;
    int          other_errors;
    int          cycle_count;

    tensor_core i_tensor_core (
        .clk          (clk),
        .reset        (reset),
        .exec_req     (exec_req),
        .exec_valid   (exec_valid),
        .exec_ready   (exec_ready),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready)
    );

    `include "tb_tensor_tasks.svh"

    always #20 clk = ~clk;

    // pick commit_ready for the coming edge and check any beat that will fire
    always @(negedge clk) begin
        case (ready_mode)
            ready_always: commit_ready = 1'b1;
            ready_held:   commit_ready = 1'b0;
            default: begin
                ready_rng    = xorshift32(ready_rng);
                commit_ready = ready_rng[3];
            end
        endcase
        if (commit_valid && commit_ready) begin
            check_commit();
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        exec_req     = '0;
        exec_valid   = 1'b0;
        commit_ready = 1'b0;
        ready_mode   = ready_always;
        op_rng       = 32'd76;
        ready_rng    = 32'd76;
        beats_seen   = 0;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        repeat (5) @(negedge clk);
        check_reset_outputs();
        reset = 1'b0;

        single_pair();
        step_selection();
        interleaved_warps();
        commit_stall();
        random_commit_ready();

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tensor_core.f
+incdir+verification
common/tensor_pkg.sv
hdl/sync_fifo.sv
octet/tensor_dpu.sv
octet/tensor_octet.sv
hdl/tensor_core.sv
verification/tb_tensor_core.sv

// File: Bender.yml
package:
  name: tensor_core

sources:
  - files:
      - common/tensor_pkg.sv
      - hdl/sync_fifo.sv
      - octet/tensor_dpu.sv
      - octet/tensor_octet.sv
      - hdl/tensor_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_tensor_core.sv
